/* logic/cgra_pkg.sv */
package cgra_pkg;

  localparam int num_threads = 8;
  localparam int imem_words  = 2048; // 256 instructions per thread.
  localparam int rf_words    = 64;   // 8 registers per thread.

  typedef logic [15:0]            data_t;
  typedef logic [15:0]            instr_t;
  typedef logic [7:0]             pc_t;
  typedef logic [2:0]             thread_t;
  typedef logic [num_threads-1:0] thread_mask_t;
  typedef logic [2:0]             rf_addr_t;
  typedef logic [63:0]            conf_word_t;

  typedef enum logic [3:0] {
    op_pass_a, op_add, op_sub, op_mul, op_and, op_or, op_xor, op_max
  } alu_op_t;

  typedef enum logic [2:0] {
    conf_none, conf_instr, conf_const, conf_pc_max, conf_pc_loop, conf_ignore
  } conf_kind_t;

  // ********************
  localparam int conf_id_hi     = 63;
  localparam int conf_id_lo     = 56;
  localparam int conf_thread_hi = 55;
  localparam int conf_thread_lo = 53;
  localparam int conf_kind_hi   = 52;
  localparam int conf_kind_lo   = 50;
  localparam int conf_addr_hi   = 49;
  localparam int conf_addr_lo   = 42;
  localparam int conf_data_hi   = 15;
  localparam int conf_data_lo   = 0;

  // ********************
  localparam int instr_op_hi    = 15;
  localparam int instr_op_lo    = 12;
  localparam int instr_mux_a    = 11; // set selects fifo_data.
  localparam int instr_mux_b    = 10; // set selects the register file.
  localparam int instr_rf_we    = 9;
  localparam int instr_fifo_re  = 8;
  localparam int instr_out_a    = 7;
  localparam int instr_out_b    = 6;
  localparam int instr_raddr_hi = 5;
  localparam int instr_raddr_lo = 3;
  localparam int instr_waddr_hi = 2;
  localparam int instr_waddr_lo = 0;

endpackage

/* logic/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode import cgra_pkg::*; (
  input  instr_t   instr,
  output alu_op_t  alu_op,
  output logic     sel_a,
  output logic     sel_b,
  output logic     rf_we,
  output logic     fifo_re,
  output logic     out_a_en,
  output logic     out_b_en,
  output rf_addr_t rf_raddr,
  output rf_addr_t rf_waddr
);

  assign alu_op   = alu_op_t'(instr[instr_op_hi:instr_op_lo]);
  assign sel_a    = instr[instr_mux_a];
  assign sel_b    = instr[instr_mux_b];
  assign rf_we    = instr[instr_rf_we];
  assign fifo_re  = instr[instr_fifo_re];
  assign out_a_en = instr[instr_out_a];
  assign out_b_en = instr[instr_out_b];
  assign rf_raddr = instr[instr_raddr_hi:instr_raddr_lo];
  assign rf_waddr = instr[instr_waddr_hi:instr_waddr_lo];

endmodule

/* logic/pe_alu.sv */
`timescale 1ns/1ps

module pe_alu import cgra_pkg::*; (
  input  alu_op_t op,
  input  data_t   a,
  input  data_t   b,
  output data_t   result
);

  always_comb begin
    case (op)
      op_pass_a: result = a;
      op_add:    result = a + b;
      op_sub:    result = a - b;
      op_mul:    result = a * b; // low half of the product.
      op_and:    result = a & b;
      op_or:     result = a | b;
      op_xor:    result = a ^ b;
      op_max:    result = (a > b) ? a : b; // unsigned compare.
      default:   result = a;
    endcase
  end

endmodule

/* logic/conf_reader.sv */
`timescale 1ns/1ps

module conf_reader import cgra_pkg::*; #(
  parameter logic [7:0] PE_ID = 8'd0
) (
  input  logic       clk,
  input  logic       arst_n,
  input  conf_word_t conf_bus,
  output logic       instr_we,
  output logic       const_we,
  output logic       pc_max_we,
  output logic       pc_loop_we,
  output logic       ignore_we,
  output thread_t    conf_thread,
  output pc_t        conf_addr,
  output data_t      conf_data
);

  conf_kind_t kind;
  logic       hit;

  assign kind = conf_kind_t'(conf_bus[conf_kind_hi:conf_kind_lo]);
  assign hit  = (conf_bus[conf_id_hi:conf_id_lo] == PE_ID) && (kind != conf_none);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      instr_we   <= 1'b0;
      const_we   <= 1'b0;
      pc_max_we  <= 1'b0;
      pc_loop_we <= 1'b0;
      ignore_we  <= 1'b0;
    end else begin
      instr_we   <= hit && (kind == conf_instr);
      const_we   <= hit && (kind == conf_const);
      pc_max_we  <= hit && (kind == conf_pc_max);
      pc_loop_we <= hit && (kind == conf_pc_loop);
      ignore_we  <= hit && (kind == conf_ignore);
    end
  end

  // words for other elements leave the last fields in place.
  always_ff @(posedge clk) begin
    if (hit) begin
      conf_thread <= conf_bus[conf_thread_hi:conf_thread_lo];
      conf_addr   <= conf_bus[conf_addr_hi:conf_addr_lo];
      conf_data   <= conf_bus[conf_data_hi:conf_data_lo];
    end
  end

endmodule

/* logic/thread_context.sv */
`timescale 1ns/1ps

module thread_context import cgra_pkg::*; #(
  parameter thread_t THREAD_INDEX = 3'd0
) (
  input  logic    clk,
  input  logic    arst_n,
  input  thread_t conf_thread,
  input  pc_t     conf_value,
  input  logic    pc_max_we,
  input  logic    pc_loop_we,
  input  logic    ignore_we,
  input  logic    step,
  input  logic    fifo_count,
  output pc_t     pc,
  output logic    ignore_done
);

  pc_t  pc_max;
  pc_t  pc_loop;
  pc_t  ignore_limit;
  pc_t  ignore_cnt;
  logic sel;

  assign sel         = (conf_thread == THREAD_INDEX);
  assign ignore_done = (ignore_cnt == ignore_limit); // the count saturates here.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_max       <= '0;
      pc_loop      <= '0;
      ignore_limit <= '0;
      ignore_cnt   <= '0;
      pc           <= '0;
    end else begin
      if (sel && pc_max_we) pc_max <= conf_value;
      if (sel && pc_loop_we) pc_loop <= conf_value;
      if (sel && ignore_we) begin
        ignore_limit <= conf_value;
        ignore_cnt   <= '0; // a new limit restarts the count.
      end else if (fifo_count && !ignore_done) begin
        ignore_cnt <= ignore_cnt + 8'd1;
      end
      if (step) pc <= (pc == pc_max) ? pc_loop : pc + 8'd1;
    end
  end

endmodule

/* logic/thread_select.sv */
`timescale 1ns/1ps

module thread_select import cgra_pkg::*; (
  input  logic         clk,
  input  logic         arst_n,
  input  logic         en,
  input  logic         fifo_req,
  input  pc_t          ctx_pc [num_threads],
  input  thread_mask_t ctx_ignore_done,
  output thread_t      fetch_thread,
  output pc_t          fetch_pc,
  output thread_mask_t fetch_onehot,
  output thread_mask_t count_onehot,
  output logic         fifo_pass
);

  thread_t thread_cnt;
  thread_t thread_dec; // thread now in the decode stage.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      thread_cnt <= '0;
      thread_dec <= '0;
    end else if (en) begin
      thread_cnt <= thread_cnt + 3'd1;
      thread_dec <= thread_cnt;
    end
  end

  assign fetch_thread = thread_cnt;
  assign fetch_pc     = ctx_pc[thread_cnt];

  // ********************
  assign fetch_onehot = en ? (thread_mask_t'(1) << thread_cnt) : '0;
  assign count_onehot = (fifo_req && en) ? (thread_mask_t'(1) << thread_dec) : '0;
  assign fifo_pass    = ctx_ignore_done[thread_dec];

endmodule

/* logic/pe_datapath.sv */
`timescale 1ns/1ps

module pe_datapath import cgra_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    en,
  input  logic    instr_we,
  input  logic    const_we,
  input  thread_t conf_thread,
  input  pc_t     conf_addr,
  input  data_t   conf_data,
  input  thread_t fetch_thread,
  input  pc_t     fetch_pc,
  input  logic    fifo_pass,
  input  data_t   ina,
  input  data_t   inb,
  input  data_t   fifo_data,
  output logic    fifo_req,
  output logic    fifo_re,
  output data_t   outa,
  output data_t   outb
);

  instr_t   imem [imem_words] = '{default: '0};
  data_t    rf [rf_words];
  instr_t   instr_q;
  instr_t   instr_dec;
  logic     en_q;
  thread_t  thread_d;
  thread_t  thread_e;
  alu_op_t  alu_op;
  alu_op_t  op_e;
  logic     sel_a;
  logic     sel_b;
  logic     sel_b_e;
  logic     rf_we;
  logic     rf_we_e;
  logic     out_a_en;
  logic     out_a_e;
  logic     out_b_en;
  logic     out_b_e;
  rf_addr_t rf_raddr;
  rf_addr_t rf_waddr;
  rf_addr_t waddr_e;
  rf_addr_t const_addr;
  data_t    a_q;
  data_t    b_q;
  data_t    rf_q;
  data_t    b_op;
  data_t    result;

  // ******************** fetch
  always_ff @(posedge clk) begin
    if (instr_we) imem[{conf_thread, conf_addr}] <= conf_data;
    if (en) instr_q <= imem[{fetch_thread, fetch_pc}];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) en_q <= 1'b0;
    else en_q <= en;
  end

  assign instr_dec = en_q ? instr_q : '0; // a stale word issues as a no-op.

  // ******************** decode
  inst_decode inst_dec (
    .instr(instr_dec), .alu_op(alu_op), .sel_a(sel_a), .sel_b(sel_b),
    .rf_we(rf_we), .fifo_re(fifo_req), .out_a_en(out_a_en), .out_b_en(out_b_en),
    .rf_raddr(rf_raddr), .rf_waddr(rf_waddr)
  );

  assign fifo_re    = fifo_req & fifo_pass & en;
  assign const_addr = rf_addr_t'(conf_addr);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      thread_d <= '0;
      thread_e <= '0;
      op_e     <= op_pass_a;
      sel_b_e  <= 1'b0;
      rf_we_e  <= 1'b0;
      out_a_e  <= 1'b0;
      out_b_e  <= 1'b0;
      waddr_e  <= '0;
    end else if (en) begin
      thread_d <= fetch_thread;
      thread_e <= thread_d;
      op_e     <= alu_op;
      sel_b_e  <= sel_b;
      rf_we_e  <= rf_we;
      out_a_e  <= out_a_en;
      out_b_e  <= out_b_en;
      waddr_e  <= rf_waddr;
    end
  end

  // configuration writes win over the write-back.
  always_ff @(posedge clk) begin
    if (en) begin
      a_q  <= sel_a ? fifo_data : ina;
      b_q  <= inb;
      rf_q <= rf[{thread_d, rf_raddr}];
    end
    if (const_we) rf[{conf_thread, const_addr}] <= conf_data;
    else if (en && rf_we_e) rf[{thread_e, waddr_e}] <= result;
  end

  // ******************** execute
  assign b_op = sel_b_e ? rf_q : b_q;

  pe_alu alu (.op(op_e), .a(a_q), .b(b_op), .result(result));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      outa <= '0;
      outb <= '0;
    end else if (en) begin
      if (out_a_e) outa <= result;
      if (out_b_e) outb <= result;
    end
  end

endmodule

/* logic/cgra_pe_in.sv */
`timescale 1ns/1ps

module cgra_pe_in import cgra_pkg::*; #(
  parameter logic [7:0] PE_ID = 8'd0
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       en,
  input  conf_word_t conf_bus,
  input  data_t      ina,
  input  data_t      inb,
  input  data_t      fifo_data,
  output data_t      outa,
  output data_t      outb,
  output logic       fifo_re
);

  logic         instr_we;
  logic         const_we;
  logic         pc_max_we;
  logic         pc_loop_we;
  logic         ignore_we;
  thread_t      conf_thread;
  pc_t          conf_addr;
  data_t        conf_data;
  pc_t          conf_value;
  thread_t      fetch_thread;
  pc_t          fetch_pc;
  thread_mask_t fetch_onehot;
  thread_mask_t count_onehot;
  thread_mask_t ctx_ignore_done;
  pc_t          ctx_pc [num_threads];
  logic         fifo_req;
  logic         fifo_pass;

  assign conf_value = pc_t'(conf_data); // bounds and limits use the low byte.

  conf_reader #(
    .PE_ID(PE_ID)
  ) conf_reader_pe (
    .clk(clk), .arst_n(arst_n), .conf_bus(conf_bus),
    .instr_we(instr_we), .const_we(const_we), .pc_max_we(pc_max_we),
    .pc_loop_we(pc_loop_we), .ignore_we(ignore_we),
    .conf_thread(conf_thread), .conf_addr(conf_addr), .conf_data(conf_data)
  );

  thread_select thread_sel (
    .clk(clk), .arst_n(arst_n), .en(en), .fifo_req(fifo_req),
    .ctx_pc(ctx_pc), .ctx_ignore_done(ctx_ignore_done),
    .fetch_thread(fetch_thread), .fetch_pc(fetch_pc),
    .fetch_onehot(fetch_onehot), .count_onehot(count_onehot), .fifo_pass(fifo_pass)
  );

  // ******************** one context per thread
  for (genvar i = 0; i < num_threads; i++) begin : g_ctx
    thread_context #(
      .THREAD_INDEX(thread_t'(i))
    ) ctx (
      .clk(clk), .arst_n(arst_n), .conf_thread(conf_thread), .conf_value(conf_value),
      .pc_max_we(pc_max_we), .pc_loop_we(pc_loop_we), .ignore_we(ignore_we),
      .step(fetch_onehot[i]), .fifo_count(count_onehot[i]),
      .pc(ctx_pc[i]), .ignore_done(ctx_ignore_done[i])
    );
  end

  pe_datapath datapath (
    .clk(clk), .arst_n(arst_n), .en(en), .instr_we(instr_we), .const_we(const_we),
    .conf_thread(conf_thread), .conf_addr(conf_addr), .conf_data(conf_data),
    .fetch_thread(fetch_thread), .fetch_pc(fetch_pc), .fifo_pass(fifo_pass),
    .ina(ina), .inb(inb), .fifo_data(fifo_data), .fifo_req(fifo_req),
    .fifo_re(fifo_re), .outa(outa), .outb(outb)
  );

endmodule

/* tests/tb_cgra_pe_in.sv */
`timescale 1ns/1ps

module tb_cgra_pe_in import cgra_pkg::*; ();

  localparam int         clk_period = 40;
  localparam int         max_cycles = 4000; // the tests need about 800 cycles.
  localparam logic [7:0] pe_id      = 8'd5;

  logic       clk;
  logic       arst_n;
  logic       en;
  conf_word_t conf_bus;
  data_t      ina;
  data_t      inb;
  data_t      fifo_data;
  data_t      outa;
  data_t      outb;
  logic       fifo_re;

  int          cycles   = 0;
  int          pulses   = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  logic [15:0] lfsr     = 16'd75;
  data_t       sum_ab; // r1 of thread 0 after the loop test.

  cgra_pe_in #(.PE_ID(pe_id)) DUT (
    .clk(clk), .arst_n(arst_n), .en(en), .conf_bus(conf_bus), .ina(ina), .inb(inb),
    .fifo_data(fifo_data), .outa(outa), .outb(outb), .fifo_re(fifo_re)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(negedge clk) begin
    if (fifo_re === 1'b1) pulses = pulses + 1; // counted mid cycle, where fifo_re is stable.
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("run timed out after %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ********************
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic random_data(output data_t v);
    v = '0;
    for (int i = 0; i < 16; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
  endtask

  function automatic data_t expected_alu(input alu_op_t op, input data_t a, input data_t b);
    logic [31:0] product;
    data_t       r;
    product = a * b;
    case (op)
      op_add:  r = a + b;
      op_sub:  r = a - b;
      op_mul:  r = product[15:0];
      op_and:  r = a & b;
      op_or:   r = a | b;
      op_xor:  r = a ^ b;
      op_max:  r = (a >= b) ? a : b;
      default: r = a;
    endcase
    return r;
  endfunction

  task automatic compare_data(input string name, input data_t exp, input data_t act);
    if (act === exp) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
      $display("FAILED %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic expect_count(input string name, input pc_t exp, input pc_t act);
    if (act === exp) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
      $display("FAILED %s: expected %0d, got %0d", name, exp, act);
    end
  endtask

  task automatic send_conf(input logic [7:0] id, input thread_t thread, input conf_kind_t kind,
                           input pc_t addr, input data_t data);
    @(posedge clk);
    conf_bus <= {id, thread, kind, addr, 26'd0, data};
  endtask

  task automatic conf_done();
    @(posedge clk);
    conf_bus <= '0;
    repeat (3) @(posedge clk); // the strobe and the write land two edges later.
  endtask

  task automatic settle();
    repeat (40) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic report(input string name, input int fails_before);
    $display("test %s finished with %0d errors", name, fail_cnt - fails_before);
  endtask

  // ******************** tests
  task automatic check_reset();
    int f0;
    f0 = fail_cnt;
    @(posedge clk);
    en <= 1'b1;
    pulses = 0;
    repeat (20) @(posedge clk);
    @(negedge clk);
    compare_data("reset outa", '0, outa);
    compare_data("reset outb", '0, outb);
    expect_count("reset fifo_re", 8'd0, pc_t'(pulses));
    report("reset", f0);
  endtask

  task automatic run_alu_ops();
    int      f0;
    data_t   c;
    data_t   a;
    alu_op_t op;
    f0 = fail_cnt;
    random_data(c);
    send_conf(pe_id, 3'd0, conf_pc_max, 8'd0, 16'd0);
    send_conf(pe_id, 3'd0, conf_const, 8'd2, c);
    conf_done();
    for (int i = 0; i < 8; i++) begin
      op = alu_op_t'(i);
      random_data(a);
      send_conf(pe_id, 3'd0, conf_instr, 8'd0, {op, 12'h490}); // b from r2, result to outa.
      ina <= a;
      conf_done();
      settle();
      compare_data($sformatf("alu %s", op.name()), expected_alu(op, a, c), outa);
    end
    report("alu", f0);
  endtask

  task automatic loop_writeback();
    int    f0;
    data_t a;
    data_t b;
    f0 = fail_cnt;
    random_data(a);
    random_data(b);
    sum_ab = a + b;
    @(posedge clk);
    ina       <= a;
    inb       <= b;
    fifo_data <= '0; // instruction 1 ors r1 into this zero.
    send_conf(pe_id, 3'd0, conf_instr, 8'd0, 16'h1201); // r1 = ina + inb.
    send_conf(pe_id, 3'd0, conf_instr, 8'd1, 16'h5c48); // outb = fifo_data | r1.
    send_conf(pe_id, 3'd0, conf_pc_max, 8'd0, 16'd1);
    send_conf(pe_id, 3'd0, conf_pc_loop, 8'd0, 16'd1);
    conf_done();
    settle();
    compare_data("loop first", sum_ab, outb);
    @(posedge clk);
    ina <= ~ina;
    settle();
    compare_data("loop hold", sum_ab, outb);
    report("loop", f0);
  endtask

  task automatic ignore_count();
    int    f0;
    data_t d;
    f0 = fail_cnt;
    random_data(d);
    @(posedge clk);
    en        <= 1'b0;
    fifo_data <= d;
    send_conf(pe_id, 3'd3, conf_ignore, 8'd0, 16'd3);
    send_conf(pe_id, 3'd3, conf_instr, 8'd0, 16'h0980); // outa = fifo_data with a fifo read.
    conf_done();
    @(posedge clk);
    en <= 1'b1;
    pulses = 0;
    repeat (81) @(posedge clk); // 80 decoded slots, ten of them for thread 3.
    en <= 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    expect_count("ignore fifo_re", 8'd7, pc_t'(pulses));
    compare_data("ignore outa", d, outa);
    @(posedge clk);
    en <= 1'b1;
    report("ignore", f0);
  endtask

  task automatic element_filter();
    int    f0;
    data_t held;
    f0 = fail_cnt;
    @(posedge clk);
    ina <= ~fifo_data;
    send_conf(8'd4, 3'd3, conf_instr, 8'd0, 16'h0080); // would pass ina to outa.
    send_conf(8'd4, 3'd0, conf_const, 8'd1, 16'hffff);
    send_conf(8'd4, 3'd0, conf_pc_max, 8'd0, 16'd0);
    conf_done();
    settle();
    compare_data("filter outa", fifo_data, outa);
    compare_data("filter outb", sum_ab | fifo_data, outb);
    held = outa;
    while (fifo_re !== 1'b1) @(negedge clk);
    repeat (8) @(posedge clk); // thread 3 is in decode again as en drops.
    en        <= 1'b0;
    fifo_data <= ~fifo_data;
    pulses = 0;
    repeat (30) @(posedge clk);
    @(negedge clk);
    expect_count("freeze fifo_re", 8'd0, pc_t'(pulses));
    compare_data("freeze outa", held, outa);
    @(posedge clk);
    en <= 1'b1;
    report("filter", f0);
  endtask

  initial begin
    arst_n    = 1'b0;
    en        = 1'b0;
    conf_bus  = '0;
    ina       = '0;
    inb       = '0;
    fifo_data = '0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    check_reset();
    run_alu_ops();
    loop_writeback();
    ignore_count();
    element_filter();
    $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* filelist.f */
logic/cgra_pkg.sv
logic/inst_decode.sv
logic/pe_alu.sv
logic/conf_reader.sv
logic/thread_context.sv
logic/thread_select.sv
logic/pe_datapath.sv
logic/cgra_pe_in.sv
tests/tb_cgra_pe_in.sv

/* Bender.yml */
package:
  name: cgra_pe_in

sources:
  - logic/cgra_pkg.sv
  - logic/inst_decode.sv
  - logic/pe_alu.sv
  - logic/conf_reader.sv
  - logic/thread_context.sv
  - logic/thread_select.sv
  - logic/pe_datapath.sv
  - logic/cgra_pe_in.sv
  - target: test
    files:
      - tests/tb_cgra_pe_in.sv
